// ==== thr_switch.f ====
hdl/thr_switch_pkg.sv
hdl/thr_ctl_if.sv
hdl/thr_fsm.sv
hdl/thr_scheduler.sv
hdl/miss_tracker.sv
hdl/thr_switch_unit.sv
verification/miss_responder.sv
verification/tb_thr_switch_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_thr_switch_unit
FLIST     := thr_switch.f

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// ==== verification/tb_thr_switch_unit.sv ====
// testbench for the thread switch unit, random control traffic
// assertions check the state table, run exclusivity, slice and miss handshake
module tb_thr_switch_unit;

   import thr_switch_pkg::*;

   localparam int NT          = 4;
   localparam int SLICE       = 8;
   localparam int TW          = 2;
   localparam int RESET_CYC   = 3;
   localparam int RAND_CYC    = 4000;

   logic clk = 1'b0;
   logic rst_thread = 1'b1;
   logic rst_q = 1'b1;
   logic [NT-1:0] start_thread, halt_thread, nuke_thread, thaw_thread;
   logic [NT-1:0] thr_reset, int_activate, spec_ld, ldhit;
   logic ld_miss, sw_cond, run_valid, miss_req, miss_ack;
   logic [TW-1:0] run_tid, miss_tid;
   req_kind_t miss_kind;
   thr_state_t [NT-1:0] thr_state;

   // previous-cycle copies for the table model
   thr_state_t [NT-1:0] p_state;
   logic [NT-1:0] p_start, p_halt, p_nuke, p_thaw, p_trst, p_int, p_spec, p_hit, p_comp;
   logic p_miss, p_cond, p_req, p_ack, p_run, p_rdy;
   logic [TW-1:0] p_tid;
   req_kind_t p_kind;
   logic [NT-1:0] outstanding;            // queued on a miss, req not yet raised
   req_kind_t exp_kind [NT];
   int run_len;                           // cycles one runner held with others ready
   logic [NT-1:0] run_hist;               // runner of last cycle, for run_len
   logic [31:0] lfsr = 32'hfca8f243;

   always #5 clk = ~clk;

   thr_switch_unit #(.NUM_THREADS(NT), .SLICE_CYCLES(SLICE)) i_thr_switch_unit (
      .clk(clk), .rst_thread(rst_thread), .start_thread(start_thread),
      .halt_thread(halt_thread), .nuke_thread(nuke_thread), .thaw_thread(thaw_thread),
      .thr_reset(thr_reset), .int_activate(int_activate), .spec_ld(spec_ld), .ldhit(ldhit),
      .ld_miss(ld_miss), .sw_cond(sw_cond), .thr_state(thr_state), .run_valid(run_valid),
      .run_tid(run_tid), .miss_req(miss_req), .miss_tid(miss_tid), .miss_kind(miss_kind),
      .miss_ack(miss_ack)
   );

   miss_responder i_miss_responder (
      .clk(clk), .rst_thread(rst_thread), .miss_req(miss_req), .miss_ack(miss_ack)
   );

   function automatic int take_bits(input int n);
      int val;
      val = 0;
      for (int k = 0; k < n; k++)
      begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};   // taps 32 22 2 1
         val  = (val << 1) | int'(lfsr[0]);
      end
      return val;
   endfunction

   function automatic logic is_run(input thr_state_t s);
      return (s == RUN) || (s == SPEC_RUN);
   endfunction

   function automatic logic is_rdy(input thr_state_t s);
      return (s == RDY) || (s == SPEC_RDY);
   endfunction

   // index of the running thread, 0 when none
   function automatic int runner_id(input logic [NT-1:0] v);
      int id;
      id = 0;
      for (int i = NT - 1; i >= 0; i--)
         if (v[i])
            id = i;
      return id;
   endfunction

   // reference state table, inputs of one thread for one cycle
   function automatic thr_state_t table_next(input thr_state_t s, input logic comp,
      input logic sch, input logic spec, input logic hit, input logic stl, input logic act,
      input logic hlt, input logic strt, input logic nuke, input logic thaw,
      input logic trst, input logic swo, input logic cond);
      case (s)
         IDLE:     return (trst | thaw) ? WAIT : strt ? RDY : IDLE;
         HALT:     return nuke ? IDLE : (trst | thaw) ? WAIT : (act | strt) ? RDY : HALT;
         RDY:      return stl ? WAIT : sch ? RUN : RDY;
         RUN:      return (stl | cond) ? WAIT : swo ? RDY : RUN;
         WAIT:     return nuke ? IDLE : hlt ? HALT : stl ? WAIT : spec ? SPEC_RDY :
                          comp ? RDY : WAIT;
         SPEC_RDY: return stl ? WAIT : sch ? (hit ? RUN : SPEC_RUN) : hit ? RDY : SPEC_RDY;
         SPEC_RUN: return (stl | cond) ? WAIT : hit ? (swo ? RDY : RUN) :
                          swo ? SPEC_RDY : SPEC_RUN;
         default:  return trst ? WAIT : nuke ? IDLE : s;
      endcase
   endfunction

   task automatic report_error(input string name, input int exp, input int act);
      $display("Error: %s expected %0h actual %0h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "check failed");
   endtask

   task automatic report_fault(input string what);
      $display("%s", what);
      $display("TEST FAIL");
      $fatal(1, "check failed");
   endtask

   // legality of every thread's change, schedule and switch_out left open
   logic legal_ok;
   int bad_thr;
   thr_state_t bad_exp;
   always_comb
   begin
      logic ok;
      legal_ok = 1'b1;
      bad_thr  = 0;
      bad_exp  = IDLE;
      for (int i = 0; i < NT; i++)
      begin
         ok = 1'b0;
         for (int s = 0; s < 2; s++)
            for (int o = 0; o < 2; o++)
               if (table_next(p_state[i], p_comp[i], s[0], p_spec[i], p_hit[i],
                      p_miss & is_run(p_state[i]), p_int[i], p_halt[i], p_start[i],
                      p_nuke[i], p_thaw[i], p_trst[i], o[0], p_cond) == thr_state[i])
                  ok = 1'b1;
         if (!ok && legal_ok)
         begin
            legal_ok = 1'b0;
            bad_thr  = i;
            bad_exp  = table_next(p_state[i], p_comp[i], 1'b0, p_spec[i], p_hit[i],
                          p_miss & is_run(p_state[i]), p_int[i], p_halt[i], p_start[i],
                          p_nuke[i], p_thaw[i], p_trst[i], 1'b0, p_cond);
         end
      end
   end

   logic [NT-1:0] run_now, rdy_now;
   always_comb
   begin
      for (int i = 0; i < NT; i++)
      begin
         run_now[i] = is_run(thr_state[i]);
         rdy_now[i] = is_rdy(thr_state[i]);
      end
   end

   always @(posedge clk)
   begin
      rst_q    <= rst_thread;
      p_state  <= thr_state;
      p_start  <= start_thread;
      p_halt   <= halt_thread;
      p_nuke   <= nuke_thread;
      p_thaw   <= thaw_thread;
      p_trst   <= thr_reset;
      p_int    <= int_activate;
      p_spec   <= spec_ld;
      p_hit    <= ldhit;
      p_miss   <= ld_miss;
      p_cond   <= sw_cond;
      p_comp   <= (miss_req && miss_ack) ? NT'(1) << miss_tid : '0;   // completion pulse
      p_req    <= miss_req;
      p_ack    <= miss_ack;
      p_tid    <= miss_tid;
      p_kind   <= miss_kind;
      p_run    <= |run_now;
      p_rdy    <= |rdy_now;
      run_hist <= run_now;
      if (rst_thread)
      begin
         outstanding <= '0;
         run_len     <= 0;
      end
      else
      begin
         if (miss_req && !p_req)
            outstanding[miss_tid] <= 1'b0;   // sent to memory
         for (int i = 0; i < NT; i++)
            if (run_now[i] && (ld_miss || sw_cond))
            begin
               outstanding[i] <= 1'b1;
               exp_kind[i]    <= ld_miss ? REQ_LOAD : REQ_COND;
            end
         if ((|run_now) && (|rdy_now))
            run_len <= (p_run && run_now == run_hist) ? run_len + 1 : 1;
         else
            run_len <= 0;
      end
   end

   a_reset: assert property (@(posedge clk) (rst_q && !rst_thread) |->
      (thr_state == '0 && !miss_req && !run_valid))
      else report_error("reset_state", 0, int'(thr_state));
   a_legal: assert property (@(posedge clk) disable iff (rst_thread || rst_q) legal_ok)
      else report_error($sformatf("state_table thread %0d", bad_thr), bad_exp,
                        thr_state[bad_thr]);
   a_one_run: assert property (@(posedge clk) disable iff (rst_thread)
      $countones(run_now) <= 1)
      else report_error("one_runner", 1, $countones(run_now));
   a_run_valid: assert property (@(posedge clk) disable iff (rst_thread)
      run_valid == (|run_now))
      else report_error("run_valid", int'(|run_now), int'(run_valid));
   a_run_tid: assert property (@(posedge clk) disable iff (rst_thread)
      run_valid |-> (run_tid == TW'(runner_id(run_now))))
      else report_error("run_tid", runner_id(run_now), int'(run_tid));
   a_progress: assert property (@(posedge clk) disable iff (rst_thread || rst_q)
      (!p_run && p_rdy) |-> (|run_now))
      else report_fault("a ready thread was not switched in while nothing ran");
   a_slice: assert property (@(posedge clk) disable iff (rst_thread) run_len <= SLICE + 1)
      else report_error("slice_length", SLICE + 1, run_len);
   a_req_rise: assert property (@(posedge clk) disable iff (rst_thread || rst_q)
      (miss_req && !p_req) |-> !p_ack)
      else report_fault("miss_req rose while miss_ack was still high");
   a_req_hold: assert property (@(posedge clk) disable iff (rst_thread || rst_q)
      (p_req && !p_ack) |-> miss_req)
      else report_fault("miss_req dropped before miss_ack");
   a_req_fall: assert property (@(posedge clk) disable iff (rst_thread || rst_q)
      (!miss_req && p_req) |-> p_ack)
      else report_fault("miss_req fell without an ack");
   a_stable: assert property (@(posedge clk) disable iff (rst_thread || rst_q)
      (miss_req && p_req) |-> (miss_tid == p_tid && miss_kind == p_kind))
      else report_error("req_payload", {p_tid, p_kind}, {miss_tid, miss_kind});
   a_req_tid: assert property (@(posedge clk) disable iff (rst_thread || rst_q)
      (miss_req && !p_req) |-> outstanding[miss_tid])
      else report_fault("miss_req names a thread with nothing outstanding");
   a_req_kind: assert property (@(posedge clk) disable iff (rst_thread || rst_q)
      (miss_req && !p_req) |-> (miss_kind == exp_kind[miss_tid]))
      else report_error("req_kind", exp_kind[miss_tid], miss_kind);

   // watchdog, test length plus margin
   initial
   begin
      #((RESET_CYC + RAND_CYC + 200) * 10);
      $display("watchdog expired before the test finished");
      $display("TEST FAIL");
      $fatal(1, "timeout");
   end

   initial
   begin
      logic [NT-1:0] v_start, v_halt, v_nuke, v_thaw, v_trst, v_int, v_spec, v_hit;
      start_thread = '0;
      halt_thread  = '0;
      nuke_thread  = '0;
      thaw_thread  = '0;
      thr_reset    = '0;
      int_activate = '0;
      spec_ld      = '0;
      ldhit        = '0;
      ld_miss      = 1'b0;
      sw_cond      = 1'b0;
      repeat (RESET_CYC) @(posedge clk);
      rst_thread <= 1'b0;
      @(posedge clk);
      @(posedge clk);
      for (int c = 0; c < RAND_CYC; c++)
      begin
         for (int i = 0; i < NT; i++)
         begin
            v_start[i] = (take_bits(3) == 0);
            v_halt[i]  = (take_bits(4) == 0);
            v_nuke[i]  = (take_bits(5) == 0);
            v_thaw[i]  = (take_bits(5) == 0);
            v_trst[i]  = (take_bits(5) == 0);
            v_int[i]   = (take_bits(4) == 0);
            v_spec[i]  = (take_bits(3) == 0);
            v_hit[i]   = (take_bits(2) == 0);
         end
         start_thread <= v_start;
         halt_thread  <= v_halt;
         nuke_thread  <= v_nuke;
         thaw_thread  <= v_thaw;
         thr_reset    <= v_trst;
         int_activate <= v_int;
         spec_ld      <= v_spec;
         ldhit        <= v_hit;
         ld_miss      <= (take_bits(3) == 0);
         sw_cond      <= (take_bits(4) == 0);
         @(posedge clk);
      end
      @(posedge clk);
      $display("TEST PASS");
      $finish;
   end

endmodule

// ==== verification/miss_responder.sv ====
// memory-side model for the four-phase miss handshake
// acks each request after a pseudo-random delay, then drops ack after req falls
module miss_responder (
   input  logic clk,
   input  logic rst_thread,
   input  logic miss_req,
   output logic miss_ack
);

   logic [31:0] lfsr = 32'hfca8f243;

   // fibonacci lfsr, taps 32 22 2 1, one step per bit
   function automatic int take_bits(input int n);
      int val;
      val = 0;
      for (int k = 0; k < n; k++)
      begin
         lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
         val  = (val << 1) | int'(lfsr[0]);
      end
      return val;
   endfunction

   initial
   begin
      int delay;
      miss_ack = 1'b0;
      forever
      begin
         @(posedge clk);
         if (!rst_thread && miss_req && !miss_ack)
         begin
            delay = take_bits(3);
            repeat (delay) @(posedge clk);
            miss_ack <= 1'b1;
            @(posedge clk);
            while (miss_req)   // wait for req to drop
               @(posedge clk);
            delay = take_bits(2);
            repeat (delay) @(posedge clk);
            miss_ack <= 1'b0;
            @(posedge clk);   // let ack low be seen
         end
      end
   end

endmodule

// ==== hdl/thr_switch_unit.sv ====
// thread switch unit top, per-thread fsms plus scheduler and miss tracker
// masks, stall gating and the run outputs are decoded here from the state codes
module thr_switch_unit #(
   parameter  int NUM_THREADS  = 4,
   parameter  int SLICE_CYCLES = 8,
   localparam int TID_W        = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1
) (
   input  logic                                          clk,
   input  logic                                          rst_thread,
   input  logic [NUM_THREADS-1:0]                        start_thread,
   input  logic [NUM_THREADS-1:0]                        halt_thread,
   input  logic [NUM_THREADS-1:0]                        nuke_thread,
   input  logic [NUM_THREADS-1:0]                        thaw_thread,
   input  logic [NUM_THREADS-1:0]                        thr_reset,
   input  logic [NUM_THREADS-1:0]                        int_activate,
   input  logic [NUM_THREADS-1:0]                        spec_ld,
   input  logic [NUM_THREADS-1:0]                        ldhit,
   input  logic                                          ld_miss,   // for the runner
   input  logic                                          sw_cond,   // for the runner
   output thr_switch_pkg::thr_state_t [NUM_THREADS-1:0] thr_state,
   output logic                                          run_valid,
   output logic [TID_W-1:0]                              run_tid,
   output logic                                          miss_req,
   output logic [TID_W-1:0]                              miss_tid,
   output thr_switch_pkg::req_kind_t                     miss_kind,
   input  logic                                          miss_ack
);

   import thr_switch_pkg::*;

   logic [NUM_THREADS-1:0] run_mask;
   logic [NUM_THREADS-1:0] rdy_mask;
   logic [NUM_THREADS-1:0] stall;

   thr_ctl_if #(.NUM_THREADS(NUM_THREADS)) ctl ();

   // decode masks from the state codes
   always_comb
   begin
      for (int i = 0; i < NUM_THREADS; i++)
      begin
         run_mask[i] = (thr_state[i] == RUN) || (thr_state[i] == SPEC_RUN);
         rdy_mask[i] = (thr_state[i] == RDY) || (thr_state[i] == SPEC_RDY);
      end
   end

   assign ctl.run_mask = run_mask;
   assign ctl.rdy_mask = rdy_mask;
   assign stall        = {NUM_THREADS{ld_miss}} & run_mask;   // miss hits runner only

   assign run_valid = |run_mask;
   assign run_tid   = TID_W'(rr_next(MAX_THREADS'(run_mask), NUM_THREADS - 1, NUM_THREADS));

   for (genvar i = 0; i < NUM_THREADS; i++)
   begin : g_thr
      thr_fsm i_thr_fsm (
         .clk          (clk),
         .rst_thread   (rst_thread),
         .completion   (ctl.completion[i]),
         .schedule     (ctl.schedule[i]),
         .spec_ld      (spec_ld[i]),
         .ldhit        (ldhit[i]),
         .stall        (stall[i]),
         .int_activate (int_activate[i]),
         .halt_thread  (halt_thread[i]),
         .start_thread (start_thread[i]),
         .nuke_thread  (nuke_thread[i]),
         .thaw_thread  (thaw_thread[i]),
         .thr_reset    (thr_reset[i]),
         .switch_out   (ctl.switch_out[i]),
         .sw_cond      (sw_cond),   // only run states look at it
         .thr_state    (thr_state[i])
      );
   end

   thr_scheduler #(
      .NUM_THREADS  (NUM_THREADS),
      .SLICE_CYCLES (SLICE_CYCLES)
   ) i_thr_scheduler (
      .clk        (clk),
      .rst_thread (rst_thread),
      .ctl        (ctl)
   );

   miss_tracker #(
      .NUM_THREADS (NUM_THREADS)
   ) i_miss_tracker (
      .clk        (clk),
      .rst_thread (rst_thread),
      .ld_miss    (ld_miss),
      .sw_cond    (sw_cond),
      .ctl        (ctl),
      .miss_req   (miss_req),
      .miss_tid   (miss_tid),
      .miss_kind  (miss_kind),
      .miss_ack   (miss_ack)
   );

endmodule

// ==== hdl/miss_tracker.sv ====
// long-latency tracker, queues waiting threads and sends them to memory
// four-phase req/ack toward the memory side, completion back to the thread
module miss_tracker #(
   parameter  int NUM_THREADS = 4,
   localparam int TID_W       = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1
) (
   input  logic                      clk,
   input  logic                      rst_thread,
   input  logic                      ld_miss,    // running thread missed a load
   input  logic                      sw_cond,    // running thread switch-and-wait
   thr_ctl_if.track                  ctl,
   output logic                      miss_req,
   output logic [TID_W-1:0]          miss_tid,
   output thr_switch_pkg::req_kind_t miss_kind,
   input  logic                      miss_ack
);

   import thr_switch_pkg::*;

   // handshake phases
   typedef enum logic [1:0]
   {
      HS_IDLE    = 2'd0,
      HS_REQ     = 2'd1,   // req high, waiting for ack
      HS_ACK_LOW = 2'd2    // req dropped, waiting for ack to fall
   } hs_state_t;

   hs_state_t              hs_state;
   logic [NUM_THREADS-1:0] pending;               // queued, not yet sent
   req_kind_t              kind_q [NUM_THREADS];  // kind per queued thread
   logic [NUM_THREADS-1:0] new_vec;               // request arriving now
   logic [TID_W-1:0]       run_tid;
   req_kind_t              new_kind;
   logic [NUM_THREADS-1:0] req_vec;
   logic [TID_W-1:0]       last_tid;              // last thread sent
   logic [TID_W-1:0]       pick_tid;
   req_kind_t              pick_kind;
   logic                   can_issue;

   // lowest set bit of the run mask gives the runner
   assign run_tid  = TID_W'(rr_next(MAX_THREADS'(ctl.run_mask), NUM_THREADS - 1,
                                    NUM_THREADS));
   assign new_vec  = (ld_miss | sw_cond) ? ctl.run_mask : '0;
   assign new_kind = ld_miss ? REQ_LOAD : REQ_COND;   // miss wins, like stall

   // new arrivals bypass the queue so req can rise next cycle
   assign req_vec   = pending | new_vec;
   assign pick_tid  = TID_W'(rr_next(MAX_THREADS'(req_vec), int'(last_tid),
                                     NUM_THREADS));
   assign pick_kind = new_vec[pick_tid] ? new_kind : kind_q[pick_tid];

   // new req only once the previous ack is low
   // idle is only entered with ack already low
   assign can_issue = (|req_vec) &&
                      ((hs_state == HS_IDLE) || (hs_state == HS_ACK_LOW && !miss_ack));

   always_ff @(posedge clk)
   begin
      if (rst_thread)
      begin
         hs_state <= HS_IDLE;
         pending  <= '0;
         last_tid <= TID_W'(NUM_THREADS - 1);
      end
      else
      begin
         pending <= can_issue ? (req_vec & ~(NUM_THREADS'(1) << pick_tid)) : req_vec;
         if (can_issue)
            last_tid <= pick_tid;
         case (hs_state)
            HS_REQ:
            begin
               if (miss_ack)
                  hs_state <= HS_ACK_LOW;   // drop req
            end
            default:   // idle or waiting for ack low
            begin
               if (can_issue)
                  hs_state <= HS_REQ;
               else if (!miss_ack)
                  hs_state <= HS_IDLE;
            end
         endcase
      end
   end

   // payload, held stable while req is up
   always_ff @(posedge clk)
   begin
      if (|new_vec)
         kind_q[run_tid] <= new_kind;
      if (can_issue)
      begin
         miss_tid  <= pick_tid;
         miss_kind <= pick_kind;
      end
   end

   assign miss_req = (hs_state == HS_REQ);

   // completion on the first cycle ack is seen
   always_comb
   begin
      ctl.completion = '0;
      if (hs_state == HS_REQ && miss_ack)
         ctl.completion[miss_tid] = 1'b1;
   end

endmodule

// ==== hdl/thr_scheduler.sv ====
// round-robin thread scheduler with a time slice
// raises schedule when nothing runs and switch_out when the slice is used up
module thr_scheduler #(
   parameter int NUM_THREADS  = 4,
   parameter int SLICE_CYCLES = 8
) (
   input  logic        clk,
   input  logic        rst_thread,
   thr_ctl_if.sched    ctl
);

   import thr_switch_pkg::*;

   localparam int TID_W = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;
   localparam int CNT_W = $clog2(SLICE_CYCLES + 1);

   logic [TID_W-1:0] last_tid;    // last thread switched in
   logic [TID_W-1:0] pick_tid;    // next ready thread after last_tid
   logic             any_run;
   logic             any_rdy;
   logic             do_sched;
   logic [CNT_W-1:0] slice_cnt;   // cycles the current runner has had
   logic             slice_done;

   assign any_run = |ctl.run_mask;
   assign any_rdy = |ctl.rdy_mask;

   // nearest ready thread after the last one we picked
   assign pick_tid = TID_W'(rr_next(MAX_THREADS'(ctl.rdy_mask), int'(last_tid),
                                    NUM_THREADS));

   // only switch someone in when the pipe has no runner
   assign do_sched = ~any_run & any_rdy;

   always_comb
   begin
      ctl.schedule = '0;
      if (do_sched)
         ctl.schedule[pick_tid] = 1'b1;   // one-hot
   end

   // round-robin pointer
   always_ff @(posedge clk)
   begin
      if (rst_thread)
         last_tid <= TID_W'(NUM_THREADS - 1);   // thread 0 goes first
      else if (do_sched)
         last_tid <= pick_tid;
   end

   // slice counter, clears whenever nobody runs
   // a runner only changes by passing through an empty run mask
   always_ff @(posedge clk)
   begin
      if (rst_thread)
         slice_cnt <= '0;
      else if (!any_run)
         slice_cnt <= '0;
      else if (!slice_done)
         slice_cnt <= slice_cnt + 1'b1;   // saturates at the slice length
   end

   assign slice_done = (slice_cnt == CNT_W'(SLICE_CYCLES));

   // switch the runner out only if someone else can take over
   // thread leaves run next cycle so this is a single pulse
   always_comb
   begin
      ctl.switch_out = '0;
      if (any_run && slice_done && any_rdy)
         ctl.switch_out = ctl.run_mask;   // hits the running thread only
   end

endmodule

// ==== hdl/thr_fsm.sv ====
// state machine for one hardware thread, one copy per thread
// tracks idle/halt/ready/run/wait and the speculative states
module thr_fsm (
   input  logic                      clk,
   input  logic                      rst_thread,     // global sync reset
   input  logic                      completion,     // waited-for op is done
   input  logic                      schedule,       // picked to switch in
   input  logic                      spec_ld,        // speculative switch in
   input  logic                      ldhit,          // speculation was right
   input  logic                      stall,          // load miss on this thread
   input  logic                      int_activate,   // wake from halt
   input  logic                      halt_thread,
   input  logic                      start_thread,   // leave idle
   input  logic                      nuke_thread,
   input  logic                      thaw_thread,
   input  logic                      thr_reset,      // per-thread reset command
   input  logic                      switch_out,     // slice expired
   input  logic                      sw_cond,        // switch and wait
   output thr_switch_pkg::thr_state_t thr_state
);

   import thr_switch_pkg::*;

   thr_state_t next_state;

   always_comb
   begin
      next_state = thr_state;   // hold by default
      case (thr_state)
         IDLE:
         begin
            if (thr_reset | thaw_thread)
               next_state = WAIT;
            else if (start_thread)
               next_state = RDY;
            // anything else ignored while idle
         end
         HALT:
         begin
            if (nuke_thread)
               next_state = IDLE;
            else if (thr_reset | thaw_thread)
               next_state = WAIT;
            else if (int_activate | start_thread)
               next_state = RDY;
         end
         RDY:
         begin
            if (stall)   // not expected here, stall is gated by run
               next_state = WAIT;
            else if (schedule)
               next_state = RUN;
         end
         RUN:
         begin
            if (stall | sw_cond)
               next_state = WAIT;
            else if (switch_out)
               next_state = RDY;   // back in the ready pool
         end
         WAIT:
         begin
            if (nuke_thread)
               next_state = IDLE;
            else if (halt_thread)
               next_state = HALT;
            else if (stall)
               next_state = WAIT;
            else if (spec_ld)
               next_state = SPEC_RDY;   // load data may come early
            else if (completion & ~halt_thread)
               next_state = RDY;
         end
         SPEC_RDY:
         begin
            if (stall)
               next_state = WAIT;
            else if (schedule & ~ldhit)
               next_state = SPEC_RUN;
            else if (schedule & ldhit)
               next_state = RUN;
            else if (ldhit)
               next_state = RDY;   // speculation confirmed
         end
         SPEC_RUN:
         begin
            if (stall | sw_cond)
               next_state = WAIT;
            else if (ldhit & switch_out)
               next_state = RDY;
            else if (ldhit & ~switch_out)
               next_state = RUN;
            else if (~ldhit & switch_out)
               next_state = SPEC_RDY;
         end
         default:
         begin
            // corrupted code, only a reset or nuke gets out
            if (thr_reset)
               next_state = WAIT;
            else if (nuke_thread)
               next_state = IDLE;
         end
      endcase
   end

   // thread state register
   always_ff @(posedge clk)
   begin
      if (rst_thread)
         thr_state <= IDLE;   // all-zero code
      else
         thr_state <= next_state;
   end

endmodule

// ==== hdl/thr_ctl_if.sv ====
// per-thread control vectors shared by scheduler, tracker and the thread fsms
// one bit per hardware thread in each vector
interface thr_ctl_if #(
   parameter int NUM_THREADS = 4
);

   logic [NUM_THREADS-1:0] schedule;     // one-hot switch-in request
   logic [NUM_THREADS-1:0] switch_out;   // one-hot forced switch-out
   logic [NUM_THREADS-1:0] completion;   // long-latency op done
   logic [NUM_THREADS-1:0] run_mask;     // thread in RUN or SPEC_RUN
   logic [NUM_THREADS-1:0] rdy_mask;     // thread in RDY or SPEC_RDY

   // scheduler side
   modport sched (
      output schedule,
      output switch_out,
      input  rdy_mask,
      input  run_mask
   );

   // miss tracker, needs to know who is running
   modport track (
      output completion,
      input  run_mask
   );

   // thread state machines
   modport fsm (
      input  schedule,
      input  switch_out,
      input  completion,
      output run_mask,
      output rdy_mask
   );

endinterface

// ==== hdl/thr_switch_pkg.sv ====
// shared types and helpers for the thread switch unit
// imported by the fsm, scheduler, tracker and top level
package thr_switch_pkg;

   // thread state codes, same bits as the tcr encoding
   typedef enum logic [4:0]
   {
      IDLE     = 5'b00000,
      HALT     = 5'b00010,
      RDY      = 5'b11001,
      RUN      = 5'b00101,
      WAIT     = 5'b00001,
      SPEC_RDY = 5'b10011,
      SPEC_RUN = 5'b00111
   } thr_state_t;

   // what a long-latency request is waiting on
   typedef enum logic
   {
      REQ_LOAD = 1'b0,   // load miss
      REQ_COND = 1'b1    // switch-and-wait
   } req_kind_t;

   localparam int MAX_THREADS = 32;   // widest request vector rr_next takes

   // round-robin pick: first set bit after last, wrapping over n bits
   // returns last when nothing is set
   function automatic int rr_next(input logic [MAX_THREADS-1:0] req,
                                  input int last, input int n);
      int idx;
      int pick;
      pick = last;
      for (int k = n; k > 0; k--)   // walk backwards so nearest wins
      begin
         idx = (last + k) % n;
         if (req[idx])
            pick = idx;
      end
      return pick;
   endfunction

endpackage
